// ==== verilog/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h8000_0000
`define RV_STRB_W    4

// instruction field slices
`define RV_F_OPCODE  6:0
`define RV_F_RD      11:7
`define RV_F_FUNCT3  14:12
`define RV_F_RS1     19:15
`define RV_F_RS2     24:20
`define RV_F_FUNCT7  31:25
`define RV_F_IMM_I   31:20

`endif

// ==== verilog/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]           word_t;
  typedef logic [$clog2(`RV_NREGS)-1:0]  reg_addr_t;
  typedef logic [`RV_STRB_W-1:0]         strb_t;

  // rv32i base major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b011_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_BRANCH = 7'b110_0011,
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_LUI    = 7'b011_0111,
    OPC_AUIPC  = 7'b001_0111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
  } alu_op_e;

  typedef enum logic {A_RS1, A_PC} a_sel_e;
  typedef enum logic {B_RS2, B_IMM} b_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_IMM} wb_sel_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_e;

endpackage

// ==== verilog/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if import rv_pkg::*; ();
  alu_op_e   alu_op;
  a_sel_e    a_sel;
  b_sel_e    b_sel;
  wb_sel_e   wb_sel;
  logic      reg_we;
  logic      mem_re;
  logic      mem_we;
  mem_size_e mem_size;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      is_ebreak;
  word_t     imm;

  modport decoder (output alu_op, a_sel, b_sel, wb_sel, reg_we, mem_re, mem_we, mem_size,
                   is_branch, is_jal, is_jalr, is_ebreak, imm);
  modport alu (input alu_op, a_sel, b_sel, imm);
  modport pc_unit (input is_branch, is_jal, is_jalr, is_ebreak, imm);
  modport mem_writeback (input wb_sel, mem_re, mem_we, mem_size, imm);
  modport reg_file (input reg_we);
endinterface

// ==== verilog/decoder.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module decoder import rv_pkg::*; (
  input  word_t              instr,
  ctrl_if.decoder            ctrl,
  output reg_addr_t          rs1,
  output reg_addr_t          rs2,
  output reg_addr_t          rd
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;
  logic        is_shift_imm;
  alu_op_e     arith_op;
  alu_op_e     br_op;

  assign opcode = opcode_e'(instr[`RV_F_OPCODE]);
  assign funct3 = instr[`RV_F_FUNCT3];
  assign funct7 = instr[`RV_F_FUNCT7];
  assign rs1    = instr[`RV_F_RS1];
  assign rs2    = instr[`RV_F_RS2];
  assign rd     = instr[`RV_F_RD];

  // slli/srli/srai carry a 5 bit shamt, not a signed imm
  assign is_shift_imm = (opcode == OPC_OP_IMM) && (funct3[1:0] == 2'b01);

  assign imm_i = is_shift_imm ? {27'b0, instr[`RV_F_RS2]}
                              : {{20{instr[31]}}, instr[`RV_F_IMM_I]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // R and I type ops share funct3, funct7[5] picks sub/sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b001:  br_op = ALU_NE;
      3'b100:  br_op = ALU_LT;
      3'b101:  br_op = ALU_GE;
      3'b110:  br_op = ALU_LTU;
      3'b111:  br_op = ALU_GEU;
      default: br_op = ALU_EQ;
    endcase
  end

  always_comb begin
    // defaults decode as a no-op
    ctrl.alu_op    = ALU_ADD;
    ctrl.a_sel     = A_RS1;
    ctrl.b_sel     = B_IMM;
    ctrl.wb_sel    = WB_ALU;
    ctrl.reg_we    = 1'b0;
    ctrl.mem_re    = 1'b0;
    ctrl.mem_we    = 1'b0;
    ctrl.mem_size  = mem_size_e'(funct3);
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.is_ebreak = 1'b0;
    ctrl.imm       = imm_i;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_we = 1'b1;
        ctrl.b_sel  = B_RS2;
        ctrl.alu_op = arith_op;
      end
      OPC_OP_IMM: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = arith_op;
      end
      OPC_LOAD: begin
        ctrl.reg_we = 1'b1;
        ctrl.mem_re = 1'b1;
        ctrl.wb_sel = WB_LOAD;
      end
      OPC_STORE: begin
        ctrl.mem_we = 1'b1;
        ctrl.imm    = imm_s;
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.b_sel     = B_RS2;
        ctrl.alu_op    = br_op;
        ctrl.imm       = imm_b;
      end
      OPC_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.imm    = imm_j;
      end
      OPC_JALR: begin
        ctrl.is_jalr = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = WB_PC4;
      end
      OPC_LUI: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_IMM;
        ctrl.imm    = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_we = 1'b1;
        ctrl.a_sel  = A_PC;  // pc + imm_u through the alu
        ctrl.imm    = imm_u;
      end
      OPC_SYSTEM: ctrl.is_ebreak = (funct3 == 3'b000) && (instr[`RV_F_IMM_I] == 12'h001);
      default: ;
    endcase
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module alu import rv_pkg::*; (
  ctrl_if.alu    ctrl,
  input  word_t  rs1_data,
  input  word_t  rs2_data,
  input  word_t  pc,
  output word_t  alu_result,
  output logic   cond_true
);

  word_t  op_a;
  word_t  op_b;
  word_t  diff;
  logic   carry;
  logic   zero;
  logic   overflow;
  logic   lt;
  logic   ltu;

  assign op_a = (ctrl.a_sel == A_PC)  ? pc       : rs1_data;
  assign op_b = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_data;

  // one subtractor for sub, slt/sltu and the branch compares
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + {{`RV_XLEN{1'b0}}, 1'b1};
  assign zero     = (diff == '0);
  assign overflow = (op_a[`RV_XLEN-1] != op_b[`RV_XLEN-1]) &&
                    (diff[`RV_XLEN-1] != op_a[`RV_XLEN-1]);
  assign lt       = diff[`RV_XLEN-1] ^ overflow;
  assign ltu      = ~carry;  // no carry out means a borrow

  always_comb begin
    case (ctrl.alu_op)
      ALU_EQ:            cond_true = zero;
      ALU_NE:            cond_true = ~zero;
      ALU_LT, ALU_SLT:   cond_true = lt;
      ALU_GE:            cond_true = ~lt;
      ALU_LTU, ALU_SLTU: cond_true = ltu;
      ALU_GEU:           cond_true = ~ltu;
      default:           cond_true = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:           alu_result = op_a + op_b;
      ALU_SUB:           alu_result = diff;
      ALU_XOR:           alu_result = op_a ^ op_b;
      ALU_OR:            alu_result = op_a | op_b;
      ALU_AND:           alu_result = op_a & op_b;
      ALU_SLL:           alu_result = op_a << op_b[4:0];
      ALU_SRL:           alu_result = op_a >> op_b[4:0];
      ALU_SRA:           alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_SLT, ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, cond_true};
      default:           alu_result = diff;  // unused by branches
    endcase
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module reg_file import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  ctrl_if.reg_file        ctrl,
  input  reg_addr_t       rs1,
  input  reg_addr_t       rs2,
  input  reg_addr_t       rd,
  input  word_t           rd_data,
  output word_t           rs1_data,
  output word_t           rs2_data
);

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_we && rd != '0) begin  // x0 never written
      regs[rd] <= rd_data;
    end
  end

  // same cycle read sees the old value
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// ==== verilog/pc_unit.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module pc_unit import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  ctrl_if.pc_unit     ctrl,
  input  word_t       rs1_data,
  input  logic        cond_true,
  output word_t       pc,
  output word_t       pc_plus4,
  output logic        halt
);

  word_t  tgt_base;
  word_t  tgt_sum;
  word_t  target;
  logic   take;
  word_t  next_pc;

  assign pc_plus4 = pc + 32'd4;

  assign tgt_base = ctrl.is_jalr ? rs1_data : pc;
  assign tgt_sum  = tgt_base + ctrl.imm;
  assign target   = {tgt_sum[`RV_XLEN-1:1], tgt_sum[0] & ~ctrl.is_jalr};  // jalr drops bit 0

  assign take    = ctrl.is_jal | ctrl.is_jalr | (ctrl.is_branch & cond_true);
  assign next_pc = take ? target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ctrl.is_ebreak)
        halt <= 1'b1;  // pc stays on the ebreak
      else
        pc <= next_pc;
    end
  end

endmodule

// ==== verilog/mem_writeback.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module mem_writeback import rv_pkg::*; (
  ctrl_if.mem_writeback  ctrl,
  input  word_t          alu_result,
  input  word_t          rs2_data,
  input  word_t          pc_plus4,
  input  word_t          dmem_rdata,
  output word_t          dmem_addr,
  output logic           dmem_re,
  output logic           dmem_we,
  output word_t          dmem_wdata,
  output strb_t          dmem_strb,
  output word_t          rd_data
);

  logic [1:0]   lane;
  logic [7:0]   ld_byte;
  logic [15:0]  ld_half;
  word_t        load_data;
  strb_t        strb;

  assign dmem_addr = alu_result;
  assign dmem_re   = ctrl.mem_re;
  assign dmem_we   = ctrl.mem_we;
  assign lane      = alu_result[1:0];

  // load lane pick
  assign ld_byte = dmem_rdata[{lane, 3'b000} +: 8];
  assign ld_half = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.mem_size)
      MEM_B:   load_data = {{24{ld_byte[7]}}, ld_byte};
      MEM_H:   load_data = {{16{ld_half[15]}}, ld_half};
      MEM_BU:  load_data = {24'b0, ld_byte};
      MEM_HU:  load_data = {16'b0, ld_half};
      default: load_data = dmem_rdata;
    endcase
  end

  // store data copied to every lane, strobe picks the one written
  always_comb begin
    case (ctrl.mem_size)
      MEM_B: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        strb       = strb_t'(1) << lane;
      end
      MEM_H: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        strb       = lane[1] ? 4'b1100 : 4'b0011;
      end
      MEM_W: begin
        dmem_wdata = rs2_data;
        strb       = {`RV_STRB_W{1'b1}};
      end
      default: begin
        dmem_wdata = rs2_data;
        strb       = '0;
      end
    endcase
  end

  assign dmem_strb = ctrl.mem_we ? strb : '0;

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: rd_data = load_data;
      WB_PC4:  rd_data = pc_plus4;  // link value
      WB_IMM:  rd_data = ctrl.imm;
      default: rd_data = alu_result;
    endcase
  end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module cpu_top import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  output word_t                  pc,
  input  word_t                  imem_rdata,
  output word_t                  dmem_addr,
  output logic                   dmem_re,
  input  word_t                  dmem_rdata,
  output logic                   dmem_we,
  output word_t                  dmem_wdata,
  output logic [`RV_STRB_W-1:0]  dmem_strb,
  output logic                   halt
);

  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      rd_data;
  word_t      alu_result;
  logic       cond_true;
  word_t      pc_plus4;

  ctrl_if ctrl ();

  decoder i_decoder (
    .instr (imem_rdata),
    .ctrl  (ctrl),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu i_alu (
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .alu_result (alu_result),
    .cond_true  (cond_true)
  );

  pc_unit i_pc_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .cond_true (cond_true),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .halt      (halt)
  );

  mem_writeback i_mem_wb (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_re    (dmem_re),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (dmem_strb),
    .rd_data    (rd_data)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 20;  // 40 ns clock

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module tb_top import rv_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int HALT_TIMEOUT = 2000;
  localparam int HOLD_CYCLES  = 10;

  logic   clk;
  logic   rst_n;
  word_t  pc;
  word_t  imem_rdata;
  word_t  dmem_addr;
  logic   dmem_re;
  word_t  dmem_rdata;
  logic   dmem_we;
  word_t  dmem_wdata;
  strb_t  dmem_strb;
  logic   halt;

  word_t  mem [word_t];  // keyed by word address
  word_t  exp_addr [$];
  word_t  exp_data [$];
  strb_t  exp_strb [$];
  word_t  exp_halt_pc = '0;
  bit     have_halt_pc = 1'b0;
  int     store_cnt = 0;
  int     value_errs = 0;
  int     other_errs = 0;
  int     seed_val;

  tb_clk_gen i_clk_gen (
    .clk (clk)
  );

  cpu_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (dmem_strb),
    .halt       (halt)
  );

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED @%0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_strb(input string what, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED @%0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED @%0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // unmapped words read back an address pattern
  function automatic word_t mem_read(input word_t addr);
    word_t key;
    key = addr >> 2;
    if (mem.exists(key))
      return mem[key];
    return {addr[31:2], 2'b00} ^ 32'h5a5a_a5a5;
  endfunction

  task automatic load_golden();
    int        fd;
    int        n;
    string     line;
    logic [7:0] kind;
    word_t     a;
    word_t     b;
    word_t     c;
    fd = $fopen("sim/rv_golden.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("ERROR: cannot open sim/rv_golden.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1) begin
        kind = line.getc(0);
        a = '0;
        b = '0;
        c = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
        case (kind)
          "I", "D": mem[a >> 2] = b;  // program and data share one space
          "S": begin
            if (n < 3) begin
              other_errs++;
              $display("ERROR: short store record in golden file: %s", line);
            end
            exp_addr.push_back(a);
            exp_data.push_back(b);
            exp_strb.push_back(strb_t'(c));
          end
          "H": begin
            exp_halt_pc  = a;
            have_halt_pc = 1'b1;
          end
          default: ;  // comment lines
        endcase
      end
    end
    $fclose(fd);
  endtask

  task automatic log_store(input word_t addr, input word_t data, input strb_t strb,
                           input logic halted);
    word_t merged;
    merged = mem_read(addr);
    if (halted) begin
      other_errs++;
      $display("ERROR: store to %h happened while the core was halted", addr);
    end
    if (store_cnt < exp_addr.size()) begin
      check_word($sformatf("store %0d addr", store_cnt), addr, exp_addr[store_cnt]);
      check_word($sformatf("store %0d data", store_cnt), data, exp_data[store_cnt]);
      check_strb($sformatf("store %0d strb", store_cnt), strb, exp_strb[store_cnt]);
    end else begin
      other_errs++;
      $display("ERROR: extra store of %h to %h, only %0d were expected",
               data, addr, exp_addr.size());
    end
    store_cnt++;
    for (int i = 0; i < `RV_STRB_W; i++) begin
      if (strb[i])
        merged[i*8 +: 8] = data[i*8 +: 8];
    end
    mem[addr >> 2] = merged;
  endtask

  // memory model stores on the edge then answers both ports
  always @(posedge clk) begin
    if (rst_n === 1'b1 && dmem_we === 1'b1) begin
      check_flag("dmem_re during store", dmem_re, 1'b0);
      log_store(dmem_addr, dmem_wdata, dmem_strb, halt);
    end
    #2;
    imem_rdata = mem_read(pc);
    #1;
    if (dmem_re === 1'b1)
      dmem_rdata = mem_read(dmem_addr);  // addr settles from the new instruction
    else
      dmem_rdata = ~mem_read(dmem_addr);  // data only valid with dmem_re
  end

  task automatic wait_for_halt(output bit timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while (halt !== 1'b1) begin
      if (cycles == HALT_TIMEOUT) begin
        timed_out = 1'b1;
        break;
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic check_halt_hold();
    if (!have_halt_pc) begin
      other_errs++;
      $display("ERROR: golden file has no halt pc record");
    end
    check_word("halt pc", pc, exp_halt_pc);
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(posedge clk);
      #2;
      check_word("pc held after halt", pc, exp_halt_pc);
      check_flag("halt held", halt, 1'b1);
    end
    if (store_cnt != exp_addr.size()) begin
      other_errs++;
      $display("ERROR: %0d stores seen but %0d expected", store_cnt, exp_addr.size());
    end
  endtask

  task automatic finish_run();
    $display("tb_top: %0d value errors, %0d other errors, %0d of %0d stores seen",
             value_errs, other_errs, store_cnt, exp_addr.size());
    if (value_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    bit timed_out;
    seed_val   = $urandom(87);
    rst_n      = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    load_golden();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #2;
      check_word("pc in reset", pc, `RV_RESET_PC);
      check_flag("halt in reset", halt, 1'b0);
    end
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    // the first program word is sequential
    check_word("pc after first instruction", pc, `RV_RESET_PC + 32'd4);
    wait_for_halt(timed_out);
    if (timed_out) begin
      other_errs++;
      $display("ERROR: halt never asserted within %0d cycles", HALT_TIMEOUT);
    end else begin
      check_halt_hold();
    end
    finish_run();
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pc_unit.sv
verilog/mem_writeback.sv
verilog/cpu_top.sv
sim/tb_clk_gen.sv
sim/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

SRCS := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv sim/*.txt)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rv_golden.txt ====
# I addr word = program word, D addr word = initial data word (hex)
# S addr data strb = expected store in order, H pc = expected halt pc
I 80000000 800010b7  # lui  x1, 0x80001
I 80000004 ffb00113  # addi x2, x0, -5
I 80000008 00700193  # addi x3, x0, 7
I 8000000c 00310233  # add  x4, x2, x3
I 80000010 0040a023  # sw   x4, 0(x1)
I 80000014 40218233  # sub  x4, x3, x2
I 80000018 0040a223  # sw   x4, 4(x1)
I 8000001c 00314233  # xor  x4, x2, x3
I 80000020 0040a423  # sw   x4, 8(x1)
I 80000024 0f017213  # andi x4, x2, 0xf0
I 80000028 0040a623  # sw   x4, 12(x1)
I 8000002c 00319233  # sll  x4, x3, x3
I 80000030 0040a823  # sw   x4, 16(x1)
I 80000034 00315233  # srl  x4, x2, x3
I 80000038 0040aa23  # sw   x4, 20(x1)
I 8000003c 40115213  # srai x4, x2, 1
I 80000040 0040ac23  # sw   x4, 24(x1)
I 80000044 00312233  # slt  x4, x2, x3
I 80000048 0040ae23  # sw   x4, 28(x1)
I 8000004c 00313233  # sltu x4, x2, x3
I 80000050 0240a023  # sw   x4, 32(x1)
I 80000054 123452b7  # lui  x5, 0x12345
I 80000058 67828293  # addi x5, x5, 0x678
I 8000005c 04508023  # sb   x5, 0x40(x1)
I 80000060 045080a3  # sb   x5, 0x41(x1)
I 80000064 04508123  # sb   x5, 0x42(x1)
I 80000068 045081a3  # sb   x5, 0x43(x1)
I 8000006c 04509223  # sh   x5, 0x44(x1)
I 80000070 04509323  # sh   x5, 0x46(x1)
I 80000074 10008303  # lb   x6, 0x100(x1)
I 80000078 0460a423  # sw   x6, 0x48(x1)
I 8000007c 1000c303  # lbu  x6, 0x100(x1)
I 80000080 0460a623  # sw   x6, 0x4c(x1)
I 80000084 10108303  # lb   x6, 0x101(x1)
I 80000088 0460a823  # sw   x6, 0x50(x1)
I 8000008c 10209303  # lh   x6, 0x102(x1)
I 80000090 0460aa23  # sw   x6, 0x54(x1)
I 80000094 1020d303  # lhu  x6, 0x102(x1)
I 80000098 0460ac23  # sw   x6, 0x58(x1)
I 8000009c 05500393  # addi x7, x0, 0x55 good marker
I 800000a0 7ad00413  # addi x8, x0, 0x7ad wrong path marker
I 800000a4 00318463  # beq  x3, x3, +8 taken
I 800000a8 0680ae23  # sw   x8, 0x7c(x1)
I 800000ac 0670a023  # sw   x7, 0x60(x1)
I 800000b0 00319463  # bne  x3, x3, +8 not taken
I 800000b4 0670a223  # sw   x7, 0x64(x1)
I 800000b8 00314463  # blt  x2, x3, +8 taken
I 800000bc 0680ae23  # sw   x8, 0x7c(x1)
I 800000c0 0670a423  # sw   x7, 0x68(x1)
I 800000c4 00315463  # bge  x2, x3, +8 not taken
I 800000c8 0670a623  # sw   x7, 0x6c(x1)
I 800000cc 00316463  # bltu x2, x3, +8 not taken
I 800000d0 0670a823  # sw   x7, 0x70(x1)
I 800000d4 00317463  # bgeu x2, x3, +8 taken
I 800000d8 0680ae23  # sw   x8, 0x7c(x1)
I 800000dc 0670aa23  # sw   x7, 0x74(x1)
I 800000e0 00001497  # auipc x9, 0x1
I 800000e4 0890a023  # sw   x9, 0x80(x1)
I 800000e8 0080056f  # jal  x10, +8
I 800000ec 0680ae23  # sw   x8, 0x7c(x1)
I 800000f0 08a0a223  # sw   x10, 0x84(x1)
I 800000f4 00000597  # auipc x11, 0
I 800000f8 00d58667  # jalr x12, 13(x11) odd target
I 800000fc 0680ae23  # sw   x8, 0x7c(x1)
I 80000100 08c0a423  # sw   x12, 0x88(x1)
I 80000104 00100073  # ebreak
D 80001100 f0e17f85
S 80001000 00000002 f
S 80001004 0000000c f
S 80001008 fffffffc f
S 8000100c 000000f0 f
S 80001010 00000380 f
S 80001014 01ffffff f
S 80001018 fffffffd f
S 8000101c 00000001 f
S 80001020 00000000 f
S 80001040 78787878 1
S 80001041 78787878 2
S 80001042 78787878 4
S 80001043 78787878 8
S 80001044 56785678 3
S 80001046 56785678 c
S 80001048 ffffff85 f
S 8000104c 00000085 f
S 80001050 0000007f f
S 80001054 fffff0e1 f
S 80001058 0000f0e1 f
S 80001060 00000055 f
S 80001064 00000055 f
S 80001068 00000055 f
S 8000106c 00000055 f
S 80001070 00000055 f
S 80001074 00000055 f
S 80001080 800010e0 f
S 80001084 800000ec f
S 80001088 800000fc f
H 80000104
